// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_mem_subsystem
out="$(./obj_dir/Vtb_mem_subsystem)"
echo "$out"
if echo "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1

// ==== source/arbiter.sv ====
`timescale 1ns/1ns

module arbiter import mem_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  cache_req_t i_icache_req,
    output cache_rsp_t o_icache_rsp,
    input  cache_req_t i_dcache_req,
    output cache_rsp_t o_dcache_rsp,
    output cache_req_t o_mem_req,
    input  cache_rsp_t i_mem_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ICACHE,
        ST_DCACHE
    } arb_state_e;

    arb_state_e state;
    arb_state_e next_state;

    logic icache_pending;
    logic dcache_pending;

    assign icache_pending = i_icache_req.read;
    assign dcache_pending = i_dcache_req.read | i_dcache_req.write;

    // data cache wins when both wait in idle.
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (dcache_pending) begin
                    next_state = ST_DCACHE;
                end else if (icache_pending) begin
                    next_state = ST_ICACHE;
                end
            end
            ST_ICACHE: begin
                if (i_mem_rsp.resp) begin
                    next_state = dcache_pending ? ST_DCACHE : ST_IDLE;
                end
            end
            ST_DCACHE: begin
                if (i_mem_rsp.resp) begin
                    next_state = icache_pending ? ST_ICACHE : ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // route the granted request out and the response back.
    always_comb begin
        o_mem_req    = '0;
        o_icache_rsp = '0;
        o_dcache_rsp = '0;
        case (state)
            ST_ICACHE: begin
                o_mem_req    = i_icache_req;
                o_icache_rsp = i_mem_rsp;
            end
            ST_DCACHE: begin
                o_mem_req    = i_dcache_req;
                o_dcache_rsp = i_mem_rsp;
            end
            default: begin
                o_mem_req = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    a_resp_granted: assert property (@(posedge clk) disable iff (rst)
        i_mem_rsp.resp |-> (state != ST_IDLE));

endmodule : arbiter

// ==== source/burst_counter.sv ====
`timescale 1ns/1ns

`include "mem_params.svh"

module burst_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_clear,
    input  logic       i_step,
    output logic [1:0] o_beat,
    output logic       o_last
);

    logic [1:0] count;

    always_ff @(posedge clk) begin
        if (rst || i_clear) begin
            count <= '0;
        end else if (i_step) begin
            count <= count + 2'd1;
        end
    end

    assign o_beat = count;

    // high while the final beat of the burst is pending.
    assign o_last = (count == 2'(`BURST_LEN - 1));

    a_no_step_on_clear: assert property (@(posedge clk) disable iff (rst)
        !(i_step && i_clear));

endmodule : burst_counter

// ==== source/cacheline_adaptor.sv ====
`timescale 1ns/1ns

`include "mem_params.svh"

module cacheline_adaptor import mem_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  cache_req_t i_req,
    output cache_rsp_t o_rsp,
    output burst_req_t o_burst_req,
    input  burst_rsp_t i_burst_rsp
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_RESP,
        ST_REST
    } adapt_state_e;

    adapt_state_e state;

    logic               in_idle;
    logic               step;
    logic               last;
    logic [1:0]         beat;
    logic [`BEAT_W-1:0] wr_beat;

    assign in_idle = (state == ST_IDLE);

    // a beat moves on rvalid in a read, on wready in a write.
    assign step = ((state == ST_READ) && i_burst_rsp.rvalid) ||
                  ((state == ST_WRITE) && i_burst_rsp.wready);

    burst_counter u_counter (
        .clk     (clk),
        .rst     (rst),
        .i_clear (in_idle),
        .i_step  (step),
        .o_beat  (beat),
        .o_last  (last)
    );

    line_buffer u_buffer (
        .clk         (clk),
        .i_load_line (in_idle && i_req.write),
        .i_line      (i_req.wdata),
        .i_load_beat ((state == ST_READ) && i_burst_rsp.rvalid),
        .i_beat_sel  (beat),
        .i_beat      (i_burst_rsp.rdata),
        .o_line      (o_rsp.rdata),
        .o_beat      (wr_beat)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_req.read) begin
                        state <= ST_READ;
                    end else if (i_req.write) begin
                        state <= ST_WRITE;
                    end
                end
                ST_READ, ST_WRITE: begin
                    if (step && last) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    state <= ST_REST;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_rsp.resp = (state == ST_RESP);

    // line aligned address held for the whole burst.
    assign o_burst_req.read    = (state == ST_READ);
    assign o_burst_req.write   = (state == ST_WRITE);
    assign o_burst_req.address = {i_req.address[31:`LINE_OFFSET_W], {`LINE_OFFSET_W{1'b0}}};
    assign o_burst_req.wdata   = wr_beat;
    assign o_burst_req.wvalid  = (state == ST_WRITE);

    a_req_held: assert property (@(posedge clk) disable iff (rst)
        (o_burst_req.read || o_burst_req.write) |-> (i_req.read || i_req.write));

endmodule : cacheline_adaptor

// ==== source/line_buffer.sv ====
`timescale 1ns/1ns

`include "mem_params.svh"

module line_buffer import rv32i_types::*; (
    input  logic               clk,
    input  logic               i_load_line,
    input  cacheline_t         i_line,
    input  logic               i_load_beat,
    input  logic [1:0]         i_beat_sel,
    input  logic [`BEAT_W-1:0] i_beat,
    output cacheline_t         o_line,
    output logic [`BEAT_W-1:0] o_beat
);

    cacheline_t line_q;

    // whole line for writes, beat by beat for reads.
    always_ff @(posedge clk) begin
        if (i_load_line) begin
            line_q <= i_line;
        end else if (i_load_beat) begin
            line_q[i_beat_sel*`BEAT_W +: `BEAT_W] <= i_beat;
        end
    end

    assign o_line = line_q;

    // current beat for write bursts.
    assign o_beat = line_q[i_beat_sel*`BEAT_W +: `BEAT_W];

endmodule : line_buffer

// ==== source/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// one cache line in bits.
`define LINE_W 256

// width of one beat on the burst bus.
`define BEAT_W 64

// beats per line transfer.
`define BURST_LEN 4

// byte offset bits within one line.
`define LINE_OFFSET_W 5

`endif

// ==== source/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem import mem_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  cache_req_t i_icache_req,
    output cache_rsp_t o_icache_rsp,
    input  cache_req_t i_dcache_req,
    output cache_rsp_t o_dcache_rsp,
    output burst_req_t o_burst_req,
    input  burst_rsp_t i_burst_rsp
);

    // granted request and its response.
    cache_req_t arb_req;
    cache_rsp_t arb_rsp;

    arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_icache_req (i_icache_req),
        .o_icache_rsp (o_icache_rsp),
        .i_dcache_req (i_dcache_req),
        .o_dcache_rsp (o_dcache_rsp),
        .o_mem_req    (arb_req),
        .i_mem_rsp    (arb_rsp)
    );

    cacheline_adaptor u_adaptor (
        .clk         (clk),
        .rst         (rst),
        .i_req       (arb_req),
        .o_rsp       (arb_rsp),
        .o_burst_req (o_burst_req),
        .i_burst_rsp (i_burst_rsp)
    );

endmodule : mem_subsystem

// ==== source/mem_types.sv ====
`include "mem_params.svh"

package mem_types;

    import rv32i_types::*;

    // line request from a cache.
    typedef struct packed {
        logic       read;
        logic       write;
        rv32i_word  address;
        cacheline_t wdata;
    } cache_req_t;

    typedef struct packed {
        logic       resp;
        cacheline_t rdata;
    } cache_rsp_t;

    // adaptor side of the burst bus.
    typedef struct packed {
        logic              read;
        logic              write;
        rv32i_word         address;
        logic [`BEAT_W-1:0] wdata;
        logic              wvalid;
    } burst_req_t;

    typedef struct packed {
        logic [`BEAT_W-1:0] rdata;
        logic              rvalid;
        logic              wready;
    } burst_rsp_t;

endpackage : mem_types

// ==== source/rv32i_types.sv ====
`include "mem_params.svh"

package rv32i_types;

    // byte address as the core sees it.
    typedef logic [31:0] rv32i_word;

    // beat 0 sits in the low 64 bits.
    typedef logic [`LINE_W-1:0] cacheline_t;

endpackage : rv32i_types

// ==== verif/burst_memory_model.sv ====
`timescale 1ns/1ns

`include "mem_params.svh"

module burst_memory_model import rv32i_types::*, mem_types::*; (
    input  logic       clk,
    input  logic       rst,
    input  burst_req_t i_burst_req,
    output burst_rsp_t o_burst_rsp
);

    cacheline_t mem [rv32i_word];
    integer     seed;
    logic [2:0] issued;
    logic [2:0] taken;
    logic [1:0] wait_left;

    initial begin
        seed        = 66;
        o_burst_rsp = '0;
    end

    // untouched lines hold the address and the beat index.
    function automatic cacheline_t stored_line(input rv32i_word addr);
        cacheline_t line;
        if (mem.exists(addr)) begin
            line = mem[addr];
        end else begin
            for (int b = 0; b < `BURST_LEN; b++) begin
                line[b*`BEAT_W +: `BEAT_W] = {addr, 32'(b)};
            end
        end
        return line;
    endfunction

    always @(posedge clk) begin : model_step
        cacheline_t line;
        line = stored_line(i_burst_req.address);
        o_burst_rsp.rvalid <= 1'b0;
        o_burst_rsp.wready <= 1'b0;
        if (rst || !(i_burst_req.read || i_burst_req.write)) begin
            issued      <= '0;
            taken       <= '0;
            wait_left   <= 2'($unsigned($random(seed)));
            o_burst_rsp.rdata <= '0;
        end else begin
            // beat accepted in the cycle that just ended.
            if (i_burst_req.write && i_burst_req.wvalid && o_burst_rsp.wready) begin
                line[taken*`BEAT_W +: `BEAT_W] = i_burst_req.wdata;
                mem[i_burst_req.address] = line;
                taken <= taken + 3'd1;
            end
            if (issued < 3'(`BURST_LEN)) begin
                if (wait_left != 2'd0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    o_burst_rsp.rvalid <= i_burst_req.read;
                    o_burst_rsp.wready <= i_burst_req.write;
                    o_burst_rsp.rdata  <= line[issued[1:0]*`BEAT_W +: `BEAT_W];
                    issued    <= issued + 3'd1;
                    wait_left <= 2'($unsigned($random(seed)));
                end
            end
        end
    end

endmodule : burst_memory_model

// ==== verif/tb_mem_subsystem.sv ====
`timescale 1ns/1ns

`include "mem_params.svh"

module tb_mem_subsystem import rv32i_types::*, mem_types::*; ();

    localparam int N_STEPS = 9;
    localparam int MAX_CYCLES = N_STEPS * 40;

    // port code 1 is the icache, 2 the dcache, 3 both.
    typedef struct packed {
        logic [1:0] ports;
        logic       d_write;
        logic [1:0] d_delay;
        rv32i_word  i_addr;
        rv32i_word  d_addr;
        cacheline_t i_exp;
        cacheline_t d_line;
        logic [1:0] first;
    } step_t;

    logic       clk;
    logic       rst;
    cache_req_t icache_req;
    cache_req_t dcache_req;
    cache_rsp_t icache_rsp;
    cache_rsp_t dcache_rsp;
    burst_req_t burst_req;
    burst_rsp_t burst_rsp;

    step_t      steps [N_STEPS];
    cacheline_t line_a;
    cacheline_t line_b;
    cacheline_t got_i;
    cacheline_t got_d;
    logic [1:0] responders [$];
    logic [4:0] idle_bits;
    int         n_checks;
    int         n_errors;
    int         cycles;

    mem_subsystem uut (
        .clk          (clk),
        .rst          (rst),
        .i_icache_req (icache_req),
        .o_icache_rsp (icache_rsp),
        .i_dcache_req (dcache_req),
        .o_dcache_rsp (dcache_rsp),
        .o_burst_req  (burst_req),
        .i_burst_rsp  (burst_rsp)
    );

    burst_memory_model u_mem (
        .clk         (clk),
        .rst         (rst),
        .i_burst_req (burst_req),
        .o_burst_rsp (burst_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory contents before any write.
    function automatic cacheline_t init_line(input rv32i_word addr);
        cacheline_t line;
        for (int b = 0; b < `BURST_LEN; b++) begin
            line[b*`BEAT_W +: `BEAT_W] = {addr, 32'(b)};
        end
        return line;
    endfunction

    function automatic step_t make_step(input logic [1:0] ports, input logic d_write,
            input logic [1:0] d_delay, input rv32i_word i_addr, input rv32i_word d_addr,
            input cacheline_t i_exp, input cacheline_t d_line, input logic [1:0] first);
        return '{ports, d_write, d_delay, i_addr, d_addr, i_exp, d_line, first};
    endfunction

    task automatic check_line(input string name, input cacheline_t got, input cacheline_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_grant(input string name, input logic [1:0] got, exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic icache_read(input rv32i_word addr);
        icache_req.read    = 1'b1;
        icache_req.address = addr;
        do begin
            @(negedge clk);
        end while (!icache_rsp.resp);
        got_i = icache_rsp.rdata;
        responders.push_back(2'd1);
        icache_req = '0;
    endtask

    task automatic dcache_access(input step_t s);
        repeat (s.d_delay) @(negedge clk);
        dcache_req.read    = !s.d_write;
        dcache_req.write   = s.d_write;
        dcache_req.address = s.d_addr;
        dcache_req.wdata   = s.d_line;
        do begin
            @(negedge clk);
        end while (!dcache_rsp.resp);
        got_d = dcache_rsp.rdata;
        responders.push_back(2'd2);
        dcache_req = '0;
    endtask

    task automatic run_step(input step_t s);
        responders.delete();
        fork
            if (s.ports[0]) icache_read(s.i_addr);
            if (s.ports[1]) dcache_access(s);
        join
        if (s.ports == 2'd3) begin
            check_grant("first responder", responders[0], s.first);
            check_grant("second responder", responders[1], s.first ^ 2'd3);
        end
        if (s.ports[0]) begin
            check_line("icache rdata", got_i, s.i_exp);
        end
        if (s.ports[1] && !s.d_write) begin
            check_line("dcache rdata", got_d, s.d_line);
        end
        @(negedge clk);
    endtask

    initial begin
        rst        = 1'b1;
        icache_req = '0;
        dcache_req = '0;
        n_checks   = 0;
        n_errors   = 0;
        for (int b = 0; b < `BURST_LEN; b++) begin
            line_a[b*`BEAT_W +: `BEAT_W] = {32'hA5A5_0000, 32'(b)};
            line_b[b*`BEAT_W +: `BEAT_W] = {32'h5A5A_0000, 32'(b + 4)};
        end
        steps[0] = make_step(2'd1, 1'b0, 2'd0, 'h1000, 'h0, init_line('h1000), '0, 2'd1);
        steps[1] = make_step(2'd2, 1'b1, 2'd0, 'h0, 'h2000, '0, line_a, 2'd2);
        steps[2] = make_step(2'd2, 1'b0, 2'd0, 'h0, 'h2000, '0, line_a, 2'd2);
        steps[3] = make_step(2'd2, 1'b0, 2'd0, 'h0, 'h3000, '0, init_line('h3000), 2'd2);
        steps[4] = make_step(2'd3, 1'b0, 2'd0, 'h1000, 'h2000, init_line('h1000), line_a, 2'd2);
        // dcache joins while the icache burst runs.
        steps[5] = make_step(2'd3, 1'b1, 2'd2, 'h4000, 'h4000, init_line('h4000), line_b, 2'd1);
        steps[6] = make_step(2'd3, 1'b0, 2'd0, 'h4000, 'h4000, line_b, line_b, 2'd2);
        steps[7] = make_step(2'd3, 1'b1, 2'd3, 'h2000, 'h3000, line_a, line_b, 2'd1);
        steps[8] = make_step(2'd1, 1'b0, 2'd0, 'h3000, 'h0, line_b, '0, 2'd1);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // nothing may move before the first request.
        repeat (5) begin
            @(negedge clk);
            idle_bits = {icache_rsp.resp, dcache_rsp.resp, burst_req.read,
                         burst_req.write, burst_req.wvalid};
            n_checks++;
            if (idle_bits !== 5'h0) begin
                n_errors++;
                $display("FAILED idle outputs: got %h expected %h", idle_bits, 5'h0);
            end
        end
        for (int n = 0; n < N_STEPS; n++) begin
            run_step(steps[n]);
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d checks, %0d errors", cycles, n_checks, n_errors);
        $display("Checks failed");
        $finish;
    end

endmodule : tb_mem_subsystem

// ==== vlog.f ====
+incdir+source
source/rv32i_types.sv
source/mem_types.sv
source/arbiter.sv
source/burst_counter.sv
source/line_buffer.sv
source/cacheline_adaptor.sv
source/mem_subsystem.sv
verif/burst_memory_model.sv
verif/tb_mem_subsystem.sv
